/* design/renamePkg.sv */
`default_nettype none

package renamePkg;

  // machine sizes
  localparam int superWidth = 2;
  localparam int numRob     = 16;
  localparam int numArch    = 32;
  localparam int numPhys    = 40;

  typedef logic [$clog2(numRob)-1:0]  robIdxT;
  typedef logic [$clog2(numArch)-1:0] archIdxT;
  typedef logic [$clog2(numPhys)-1:0] physIdxT;

  typedef struct packed {
    archIdxT destArch;
    logic    halt;
  } dispatchLaneT;

  // lane 0 is the older instruction
  typedef struct packed {
    dispatchLaneT [superWidth-1:0] lane;
  } dispatchPacketT;

  typedef struct packed {
    logic   [superWidth-1:0] enable;
    robIdxT [superWidth-1:0] robIdx;
  } completePacketT;

  typedef struct packed {
    logic    enable;
    archIdxT destArch;
    physIdxT newPhys;
    physIdxT oldPhys;
    logic    halt;
  } retireLaneT;

  typedef struct packed {
    retireLaneT [superWidth-1:0] lane;
  } retirePacketT;

  typedef struct packed {
    logic    valid;
    logic    complete;
    logic    halt;
    archIdxT destArch;
    physIdxT newPhys;
    physIdxT oldPhys;
  } robEntryT;

endpackage

`default_nettype wire

/* design/archMap.sv */
`timescale 1ns/10ps
`default_nettype none

module archMap import renamePkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  retirePacketT            retirePacket,
  output physIdxT   [numArch-1:0] archMapping
);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numArch; i++) begin
        archMapping[i] <= physIdxT'(i);
      end
    end else begin
      // retire order, so the younger lane lands last
      for (int l = 0; l < superWidth; l++) begin
        if (retirePacket.lane[l].enable) begin
          archMapping[retirePacket.lane[l].destArch] <= retirePacket.lane[l].newPhys;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/freeList.sv */
`timescale 1ns/10ps
`default_nettype none

module freeList import renamePkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       allocate,
  input  retirePacketT               retirePacket,
  input  logic                       restoreMap,
  input  physIdxT   [numArch-1:0]    archMapping,
  output logic                       twoFree,
  output physIdxT   [superWidth-1:0] newTags
);

  logic [numPhys-1:0] freeBits;
  logic [numPhys-1:0] releaseBits;
  logic [numPhys-1:0] availBits;
  logic [numPhys-1:0] claimBits;
  logic [numPhys-1:0] mappedBits;
  logic               firstFound;
  logic               secondFound;

  // registers handed back by this cycle's retire
  always_comb begin
    releaseBits = '0;
    for (int l = 0; l < superWidth; l++) begin
      if (retirePacket.lane[l].enable) begin
        releaseBits[retirePacket.lane[l].oldPhys] = 1'b1;
      end
    end
  end

  assign availBits = freeBits | releaseBits;

  // two lowest free registers, lane 0 gets the lower
  always_comb begin
    firstFound  = 1'b0;
    secondFound = 1'b0;
    newTags     = '0;
    for (int i = 0; i < numPhys; i++) begin
      if (availBits[i]) begin
        if (!firstFound) begin
          newTags[0] = physIdxT'(i);
          firstFound = 1'b1;
        end else if (!secondFound) begin
          newTags[1]  = physIdxT'(i);
          secondFound = 1'b1;
        end
      end
    end
  end

  assign twoFree = secondFound;

  always_comb begin
    claimBits = '0;
    if (allocate) begin
      for (int l = 0; l < superWidth; l++) begin
        claimBits[newTags[l]] = 1'b1;
      end
    end
  end

  always_comb begin
    mappedBits = '0;
    for (int r = 0; r < numArch; r++) begin
      mappedBits[archMapping[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numPhys; i++) begin
        freeBits[i] <= (i >= numArch);
      end
    end else if (restoreMap) begin
      freeBits <= ~mappedBits;
    end else begin
      freeBits <= availBits & ~claimBits;
    end
  end

endmodule

`default_nettype wire

/* design/mapTable.sv */
`timescale 1ns/10ps
`default_nettype none

module mapTable import renamePkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatchFire,
  input  dispatchPacketT             dispatchPacket,
  input  physIdxT   [superWidth-1:0] newTags,
  input  logic                       restoreMap,
  input  physIdxT   [numArch-1:0]    archMapping,
  output physIdxT   [superWidth-1:0] oldTags
);

  physIdxT specMap [numArch];

  always_comb begin
    oldTags[0] = specMap[dispatchPacket.lane[0].destArch];
    // lane 1 sees lane 0's rename when both write the same register
    if (dispatchPacket.lane[1].destArch == dispatchPacket.lane[0].destArch) begin
      oldTags[1] = newTags[0];
    end else begin
      oldTags[1] = specMap[dispatchPacket.lane[1].destArch];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numArch; i++) begin
        specMap[i] <= physIdxT'(i);
      end
    end else if (restoreMap) begin
      for (int i = 0; i < numArch; i++) begin
        specMap[i] <= archMapping[i];
      end
    end else if (dispatchFire) begin
      // later lane is written last and wins
      for (int l = 0; l < superWidth; l++) begin
        specMap[dispatchPacket.lane[l].destArch] <= newTags[l];
      end
    end
  end

endmodule

`default_nettype wire

/* design/reorderBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module reorderBuffer import renamePkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          runEnable,
  input  logic                          dispatchFire,
  input  dispatchPacketT                dispatchPacket,
  input  physIdxT      [superWidth-1:0] newTags,
  input  physIdxT      [superWidth-1:0] oldTags,
  input  completePacketT                completePacket,
  input  logic                          rollbackEn,
  input  robIdxT                        rollbackIdx,
  output logic                          slotsFree,
  output robIdxT                        dispatchRobIdx,
  output retirePacketT                  retirePacket,
  output logic                          recovering,
  output logic                          restoreMap
);

  robEntryT entries [numRob];
  robEntryT nextEntries [numRob];

  robIdxT head;
  robIdxT tail;
  robIdxT nextHead;
  robIdxT nextTail;
  robIdxT branchAge;
  robIdxT retireSlot [superWidth];
  robIdxT dispatchSlot [superWidth];

  logic [superWidth-1:0] retireEn;
  logic                  tailFree0;
  logic                  tailFree1;
  logic                  mispredict;
  logic                  robEmpty;

  assign retireSlot[0]   = head;
  assign retireSlot[1]   = head + robIdxT'(1);
  assign dispatchSlot[0] = tail;
  assign dispatchSlot[1] = tail + robIdxT'(1);

  // valid entries always run contiguously from head
  assign robEmpty   = !entries[head].valid;
  assign mispredict = rollbackEn && entries[rollbackIdx].valid;
  assign branchAge  = rollbackIdx - head;

  // head pair retires in order, nothing past a halt
  always_comb begin
    retireEn[0] = runEnable && entries[head].valid && entries[head].complete;
    retireEn[1] = retireEn[0] && !entries[head].halt
                  && entries[retireSlot[1]].valid && entries[retireSlot[1]].complete;
  end

  always_comb begin
    for (int l = 0; l < superWidth; l++) begin
      retirePacket.lane[l].enable   = retireEn[l];
      retirePacket.lane[l].destArch = entries[retireSlot[l]].destArch;
      retirePacket.lane[l].newPhys  = entries[retireSlot[l]].newPhys;
      retirePacket.lane[l].oldPhys  = entries[retireSlot[l]].oldPhys;
      retirePacket.lane[l].halt     = entries[retireSlot[l]].halt;
    end
  end

  // a tail slot counts as free when it is retiring this cycle
  assign tailFree0 = !entries[dispatchSlot[0]].valid
                     || (dispatchSlot[0] == retireSlot[0] && retireEn[0])
                     || (dispatchSlot[0] == retireSlot[1] && retireEn[1]);
  assign tailFree1 = !entries[dispatchSlot[1]].valid
                     || (dispatchSlot[1] == retireSlot[0] && retireEn[0])
                     || (dispatchSlot[1] == retireSlot[1] && retireEn[1]);
  assign slotsFree = tailFree0 && tailFree1;

  assign dispatchRobIdx = tail;
  assign restoreMap     = runEnable && recovering && robEmpty;

  always_comb begin
    nextEntries = entries;
    nextTail    = tail;
    nextHead    = head + robIdxT'(retireEn[0]) + robIdxT'(retireEn[1]);

    for (int l = 0; l < superWidth; l++) begin
      if (completePacket.enable[l] && entries[completePacket.robIdx[l]].valid) begin
        nextEntries[completePacket.robIdx[l]].complete = 1'b1;
      end
    end

    for (int l = 0; l < superWidth; l++) begin
      if (retireEn[l]) begin
        nextEntries[retireSlot[l]].valid = 1'b0;
      end
    end

    // dispatch after retire so a reused slot ends up valid
    if (dispatchFire) begin
      for (int l = 0; l < superWidth; l++) begin
        nextEntries[dispatchSlot[l]] = '{
          valid:    1'b1,
          complete: 1'b0,
          halt:     dispatchPacket.lane[l].halt,
          destArch: dispatchPacket.lane[l].destArch,
          newPhys:  newTags[l],
          oldPhys:  oldTags[l]
        };
      end
      nextTail = tail + robIdxT'(superWidth);
    end

    // squash everything younger than the branch, age measured from head
    if (mispredict) begin
      for (int i = 0; i < numRob; i++) begin
        if (robIdxT'(i - head) > branchAge) begin
          nextEntries[i].valid = 1'b0;
        end
      end
      nextTail = rollbackIdx + robIdxT'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      recovering <= 1'b0;
      for (int i = 0; i < numRob; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (runEnable) begin
      head    <= nextHead;
      tail    <= nextTail;
      entries <= nextEntries;
      if (mispredict) begin
        recovering <= 1'b1;
      end else if (restoreMap) begin
        recovering <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/renameControl.sv */
`timescale 1ns/10ps
`default_nettype none

module renameControl import renamePkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         start,
  input  retirePacketT retirePacket,
  input  logic         slotsFree,
  input  logic         twoFree,
  input  logic         recovering,
  input  logic         rollbackEn,
  input  logic         dispatchValid,
  output logic         runEnable,
  output logic         halted,
  output logic         dispatchReady,
  output logic         dispatchFire,
  output logic [15:0]  retiredCount
);

  logic haltRetire;
  logic [1:0] retireLanes;

  always_comb begin
    haltRetire  = 1'b0;
    retireLanes = '0;
    for (int l = 0; l < superWidth; l++) begin
      haltRetire  = haltRetire | (retirePacket.lane[l].enable & retirePacket.lane[l].halt);
      retireLanes = retireLanes + 2'(retirePacket.lane[l].enable);
    end
  end

  // the one place dispatch readiness is decided
  assign dispatchReady = slotsFree && twoFree && runEnable && !recovering && !rollbackEn;
  assign dispatchFire  = dispatchValid && dispatchReady;

  always_ff @(posedge clock) begin
    if (reset) begin
      runEnable    <= 1'b0;
      halted       <= 1'b0;
      retiredCount <= '0;
    end else begin
      retiredCount <= retiredCount + 16'(retireLanes);
      // a retiring halt takes priority over start
      if (haltRetire) begin
        runEnable <= 1'b0;
        halted    <= 1'b1;
      end else if (start) begin
        runEnable <= 1'b1;
        halted    <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/renameTop.sv */
`timescale 1ns/10ps
`default_nettype none

module renameTop import renamePkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          dispatchValid,
  input  dispatchPacketT                dispatchPacket,
  input  completePacketT                completePacket,
  input  logic                          rollbackEn,
  input  robIdxT                        rollbackIdx,
  output logic                          dispatchReady,
  output physIdxT      [superWidth-1:0] dispatchTags,
  output robIdxT                        dispatchRobIdx,
  output retirePacketT                  retirePacket,
  output logic                          halted,
  output logic         [15:0]           retiredCount
);

  logic                       runEnable;
  logic                       dispatchFire;
  logic                       slotsFree;
  logic                       twoFree;
  logic                       recovering;
  logic                       restoreMap;
  physIdxT   [superWidth-1:0] oldTags;
  physIdxT   [numArch-1:0]    archMapping;

  reorderBuffer i_reorderBuffer (
    .clock          (clock),
    .reset          (reset),
    .runEnable      (runEnable),
    .dispatchFire   (dispatchFire),
    .dispatchPacket (dispatchPacket),
    .newTags        (dispatchTags),
    .oldTags        (oldTags),
    .completePacket (completePacket),
    .rollbackEn     (rollbackEn),
    .rollbackIdx    (rollbackIdx),
    .slotsFree      (slotsFree),
    .dispatchRobIdx (dispatchRobIdx),
    .retirePacket   (retirePacket),
    .recovering     (recovering),
    .restoreMap     (restoreMap)
  );

  // allocated tags go straight out as dispatchTags
  freeList i_freeList (
    .clock        (clock),
    .reset        (reset),
    .allocate     (dispatchFire),
    .retirePacket (retirePacket),
    .restoreMap   (restoreMap),
    .archMapping  (archMapping),
    .twoFree      (twoFree),
    .newTags      (dispatchTags)
  );

  mapTable i_mapTable (
    .clock          (clock),
    .reset          (reset),
    .dispatchFire   (dispatchFire),
    .dispatchPacket (dispatchPacket),
    .newTags        (dispatchTags),
    .restoreMap     (restoreMap),
    .archMapping    (archMapping),
    .oldTags        (oldTags)
  );

  archMap i_archMap (
    .clock        (clock),
    .reset        (reset),
    .retirePacket (retirePacket),
    .archMapping  (archMapping)
  );

  renameControl i_renameControl (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .retirePacket  (retirePacket),
    .slotsFree     (slotsFree),
    .twoFree       (twoFree),
    .recovering    (recovering),
    .rollbackEn    (rollbackEn),
    .dispatchValid (dispatchValid),
    .runEnable     (runEnable),
    .halted        (halted),
    .dispatchReady (dispatchReady),
    .dispatchFire  (dispatchFire),
    .retiredCount  (retiredCount)
  );

endmodule

`default_nettype wire

/* verification/renameModel.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// one in-flight instruction as the model sees it
typedef struct packed {
  robIdxT  robIdx;
  logic    complete;
  logic    halt;
  archIdxT destArch;
  physIdxT newPhys;
  physIdxT oldPhys;
} modelEntryT;

// oldest entry sits at the front
modelEntryT         modelRob [$];
robIdxT             modelTail;
physIdxT            modelSpec [numArch];
physIdxT            modelArch [numArch];
logic [numPhys-1:0] modelFree;
logic               modelRun;
logic               modelRecovering;
logic               modelHalted;
int                 modelRetired;

function automatic void resetModel();
  modelRob.delete();
  modelTail = '0;
  for (int r = 0; r < numArch; r++) begin
    modelSpec[r] = physIdxT'(r);
    modelArch[r] = physIdxT'(r);
  end
  // only the registers above the architectural range start free
  for (int p = 0; p < numPhys; p++) begin
    modelFree[p] = (p >= numArch);
  end
  modelRun        = 1'b0;
  modelRecovering = 1'b0;
  modelHalted     = 1'b0;
  modelRetired    = 0;
endfunction

// lanes retiring this cycle, stopping after a halt
function automatic int retireCount();
  int n = 0;
  if (modelRun && modelRob.size() > 0 && modelRob[0].complete) begin
    n = 1;
    if (!modelRob[0].halt && modelRob.size() > 1 && modelRob[1].complete) begin
      n = 2;
    end
  end
  return n;
endfunction

// n-th lowest set bit, or -1
function automatic int nthFree(logic [numPhys-1:0] pool, int n);
  int seen = 0;
  for (int p = 0; p < numPhys; p++) begin
    if (pool[p]) begin
      if (seen == n) begin
        return p;
      end
      seen++;
    end
  end
  return -1;
endfunction

function automatic int findEntry(robIdxT idx);
  for (int i = 0; i < modelRob.size(); i++) begin
    if (modelRob[i].robIdx == idx) begin
      return i;
    end
  end
  return -1;
endfunction

// free set rebuilt after recovery
function automatic logic [numPhys-1:0] unmappedRegs();
  logic [numPhys-1:0] pool;
  pool = '1;
  for (int r = 0; r < numArch; r++) begin
    pool[modelArch[r]] = 1'b0;
  end
  return pool;
endfunction

`endif

/* verification/renameTb.sv */
`timescale 1ns/10ps
`default_nettype none

module renameTb import renamePkg::*;;

  localparam int lenAlloc    = 300;
  localparam int lenPressure = 300;
  localparam int lenRollback = 400;
  localparam int lenHalt     = 300;
  localparam int totalCycles = lenAlloc + lenPressure + lenRollback + lenHalt;

  logic                     clock;
  logic                     reset;
  logic                     start;
  logic                     dispatchValid;
  dispatchPacketT           dispatchPacket;
  completePacketT           completePacket;
  logic                     rollbackEn;
  robIdxT                   rollbackIdx;
  logic                     dispatchReady;
  physIdxT [superWidth-1:0] dispatchTags;
  robIdxT                   dispatchRobIdx;
  retirePacketT             retirePacket;
  logic                     halted;
  logic [15:0]              retiredCount;

  logic [31:0] lcgState;
  int          errorCount;
  int          checkCount;

  `include "renameModel.svh"

  renameTop i_renameTop (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .dispatchValid  (dispatchValid),
    .dispatchPacket (dispatchPacket),
    .completePacket (completePacket),
    .rollbackEn     (rollbackEn),
    .rollbackIdx    (rollbackIdx),
    .dispatchReady  (dispatchReady),
    .dispatchTags   (dispatchTags),
    .dispatchRobIdx (dispatchRobIdx),
    .retirePacket   (retirePacket),
    .halted         (halted),
    .retiredCount   (retiredCount)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  function automatic logic [31:0] randomBits();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic rollPercent(int pct);
    return ((randomBits() >> 16) % 100) < pct;
  endfunction

  function automatic int pickBelow(int n);
    return int'((randomBits() >> 16) % 32'(n));
  endfunction

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    checkCount++;
    assert (actual == expected) else begin
      errorCount++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
               $time);
    end
  endtask

  // check outputs at the falling edge, then step the model at the rising edge
  task automatic stepCycle();
    int                 nRet;
    int                 tag0;
    int                 tag1;
    int                 pos;
    logic               expReady;
    logic               accept;
    logic               restore;
    logic               haltSeen;
    logic [numPhys-1:0] avail;
    physIdxT            old0;
    physIdxT            old1;
    modelEntryT         e;

    @(negedge clock);
    nRet = retireCount();
    avail = modelFree;
    for (int l = 0; l < nRet; l++) begin
      avail[modelRob[l].oldPhys] = 1'b1;
    end
    tag0 = nthFree(avail, 0);
    tag1 = nthFree(avail, 1);
    expReady = modelRun && !modelRecovering && !rollbackEn
               && (numRob - modelRob.size() + nRet >= 2) && tag1 >= 0;
    checkValue("dispatchReady", 32'(expReady), 32'(dispatchReady));
    checkValue("halted", 32'(modelHalted), 32'(halted));
    checkValue("retiredCount", modelRetired % 65536, 32'(retiredCount));
    for (int l = 0; l < superWidth; l++) begin
      checkValue($sformatf("retirePacket.lane[%0d].enable", l), 32'(l < nRet),
                 32'(retirePacket.lane[l].enable));
      if (l < nRet) begin
        checkValue($sformatf("retirePacket.lane[%0d].destArch", l),
                   32'(modelRob[l].destArch), 32'(retirePacket.lane[l].destArch));
        checkValue($sformatf("retirePacket.lane[%0d].newPhys", l),
                   32'(modelRob[l].newPhys), 32'(retirePacket.lane[l].newPhys));
        checkValue($sformatf("retirePacket.lane[%0d].oldPhys", l),
                   32'(modelRob[l].oldPhys), 32'(retirePacket.lane[l].oldPhys));
        checkValue($sformatf("retirePacket.lane[%0d].halt", l),
                   32'(modelRob[l].halt), 32'(retirePacket.lane[l].halt));
      end
    end
    accept = expReady && dispatchValid;
    if (accept) begin
      checkValue("dispatchTags[0]", tag0, 32'(dispatchTags[0]));
      checkValue("dispatchTags[1]", tag1, 32'(dispatchTags[1]));
      checkValue("dispatchRobIdx", 32'(modelTail), 32'(dispatchRobIdx));
    end
    pos = rollbackEn ? findEntry(rollbackIdx) : -1;

    @(posedge clock);
    haltSeen = 1'b0;
    if (modelRun) begin
      restore = modelRecovering && modelRob.size() == 0;
      for (int l = 0; l < superWidth; l++) begin
        if (completePacket.enable[l] && findEntry(completePacket.robIdx[l]) >= 0) begin
          e = modelRob[findEntry(completePacket.robIdx[l])];
          e.complete = 1'b1;
          modelRob[findEntry(completePacket.robIdx[l])] = e;
        end
      end
      // squash everything younger than the branch
      if (pos >= 0) begin
        while (modelRob.size() > pos + 1) begin
          modelRob.delete(modelRob.size() - 1);
        end
        modelTail = rollbackIdx + robIdxT'(1);
        modelRecovering = 1'b1;
      end
      for (int l = 0; l < nRet; l++) begin
        e = modelRob.pop_front();
        modelArch[e.destArch] = e.newPhys;
        modelRetired++;
        haltSeen = haltSeen | e.halt;
      end
      if (restore) begin
        modelFree = unmappedRegs();
        modelSpec = modelArch;
        modelRecovering = 1'b0;
      end else begin
        modelFree = avail;
        if (accept) begin
          modelFree[tag0] = 1'b0;
          modelFree[tag1] = 1'b0;
          old0 = modelSpec[dispatchPacket.lane[0].destArch];
          old1 = modelSpec[dispatchPacket.lane[1].destArch];
          if (dispatchPacket.lane[1].destArch == dispatchPacket.lane[0].destArch) begin
            old1 = physIdxT'(tag0);
          end
          modelRob.push_back('{modelTail, 1'b0, dispatchPacket.lane[0].halt,
                               dispatchPacket.lane[0].destArch, physIdxT'(tag0), old0});
          modelRob.push_back('{modelTail + robIdxT'(1), 1'b0, dispatchPacket.lane[1].halt,
                               dispatchPacket.lane[1].destArch, physIdxT'(tag1), old1});
          modelSpec[dispatchPacket.lane[0].destArch] = physIdxT'(tag0);
          modelSpec[dispatchPacket.lane[1].destArch] = physIdxT'(tag1);
          modelTail = modelTail + robIdxT'(2);
        end
      end
    end
    if (haltSeen) begin
      modelRun = 1'b0;
      modelHalted = 1'b1;
    end else if (start) begin
      modelRun = 1'b1;
      modelHalted = 1'b0;
    end
  endtask

  task automatic driveInputs(int dispPct, int compPct, int rbPct, int haltPct);
    dispatchPacketT pkt;
    completePacketT cmp;
    int             open [$];
    int             first;
    int             pos;

    for (int l = 0; l < superWidth; l++) begin
      pkt.lane[l].destArch = archIdxT'(randomBits() >> 20);
      pkt.lane[l].halt = rollPercent(haltPct);
    end
    // same destination on both lanes now and then
    if (rollPercent(20)) begin
      pkt.lane[1].destArch = pkt.lane[0].destArch;
    end
    for (int i = 0; i < modelRob.size(); i++) begin
      if (!modelRob[i].complete) begin
        open.push_back(i);
      end
    end
    // out-of-order completions
    cmp = '0;
    for (int l = 0; l < superWidth; l++) begin
      if (open.size() > 0 && rollPercent(compPct)) begin
        cmp.enable[l] = 1'b1;
        cmp.robIdx[l] = modelRob[open[pickBelow(open.size())]].robIdx;
      end
    end
    start          <= 1'b0;
    dispatchValid  <= rollPercent(dispPct);
    dispatchPacket <= pkt;
    completePacket <= cmp;
    rollbackEn     <= 1'b0;
    // no lane younger than the branch retires in the same cycle
    if (modelRun && !modelRecovering && modelRob.size() > 0 && rollPercent(rbPct)) begin
      first = retireCount() > 0 ? retireCount() - 1 : 0;
      pos = first + pickBelow(modelRob.size() - first);
      rollbackEn  <= 1'b1;
      rollbackIdx <= modelRob[pos].robIdx;
    end
  endtask

  task automatic runTest(string name, int cycles, int dispPct, int compPct, int rbPct,
                         int haltPct);
    int errorsBefore;
    errorsBefore = errorCount;
    repeat (cycles) begin
      stepCycle();
      driveInputs(dispPct, compPct, rbPct, haltPct);
    end
    $display("test %s done after %0d cycles, %0d errors", name, cycles,
             errorCount - errorsBefore);
  endtask

  initial begin
    #((totalCycles + 16 + 100) * 10);
    $display("run timed out before the last test finished");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    lcgState       = 32'h4256;
    errorCount     = 0;
    checkCount     = 0;
    reset          = 1'b1;
    start          = 1'b0;
    dispatchValid  = 1'b0;
    dispatchPacket = '0;
    completePacket = '0;
    rollbackEn     = 1'b0;
    rollbackIdx    = '0;
    resetModel();
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    start <= 1'b1;
    runTest("allocation and retire order", lenAlloc, 60, 50, 0, 0);
    runTest("back-pressure", lenPressure, 90, 20, 0, 0);
    runTest("rollback and restore", lenRollback, 60, 50, 5, 0);
    runTest("halt and retire count", lenHalt, 60, 50, 0, 4);
    assert (modelHalted) else begin
      errorCount++;
      $display("no halt instruction retired during the halt test");
    end
    $display("4 tests, %0d checks, %0d errors, %0d instructions retired", checkCount,
             errorCount, modelRetired);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verification
design/renamePkg.sv
design/archMap.sv
design/freeList.sv
design/mapTable.sv
design/reorderBuffer.sv
design/renameControl.sv
design/renameTop.sv
verification/renameTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f \
  --top-module renameTb -Mdir obj_dir \
  && ./obj_dir/VrenameTb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
